/* include/x68k_glue_cfg.svh */
// X68000 glue configuration
`ifndef X68K_GLUE_CFG_SVH
`define X68K_GLUE_CFG_SVH

////////////////////////////////////////////////////////////
// Clock enable dividers
////////////////////////////////////////////////////////////

// System divider width, sys_ce once per 2**W cycles
`define SYS_DIV_W 2
// Sound divider terminal counts, periods 10 and 5
`define SND_SLOW_TERM 9
`define SND_FAST_TERM 4
// FM synth slow divider, period 20
`define OPN_TERM 19

////////////////////////////////////////////////////////////
// Audio compressor curves
////////////////////////////////////////////////////////////

// Curve 1 knee and base, gentle
`define CMP_X1 14043
`define CMP_B1 28086
// Curve 2 knee and base, heavy
`define CMP_X2 7399
`define CMP_B2 29596
// Slope divider above knee, gain below knee
`define CMP_F1 4
`define CMP_A1 2
`define CMP_F2 8
`define CMP_A2 4

// Hold times in clk_sys cycles
`define LCD_HOLD_DEFAULT 180000000
`define LED_HOLD_DEFAULT 4500000

`endif

/* design/x68k_ctrl_pkg.sv */
// X68000 glue control types
`default_nettype none

package x68k_ctrl_pkg;

	// Clock enables handed to the core
	// All are single-cycle strobes on clk_sys
	typedef struct packed {
		// System bus enable
		logic       sys_ce;
		// CPU positive and negative phase enables
		logic       mpu_cep;
		logic       mpu_cen;
		// Sound block enable, rate set by the core's clock mode
		logic       snd_ce;
		// FM synth enables, bit 1 is the slower one
		logic [1:0] opn_ce;
	} clk_en_t;

	// Reset requests, any one of them holds the core in reset
	typedef struct packed {
		// User button on the board
		logic button;
		// Reset from the OSD menu
		logic menu;
		// Reset from the platform top level
		logic external;
	} rst_src_t;

	// ROM download signals from the host
	typedef struct packed {
		// High for the whole transfer
		logic download;
		// One strobe per byte
		logic wr;
	} host_dl_t;

	// Core loader controls
	typedef struct packed {
		// Loader owns the memory bus
		logic aen;
		// Write pending, held until the core acks
		logic wr;
		// Image loaded, sticky until reset
		logic done;
	} ldr_ctl_t;

endpackage

`default_nettype wire

/* design/x68k_media_pkg.sv */
// X68000 glue media types
`default_nettype none

package x68k_media_pkg;

	// Signed PCM sample, same format for core and synth
	typedef logic signed [15:0] sample_t;

	// 24-bit RGB pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// Synth engine reported by the MT32 board
	// Any other code means the mode is not known
	typedef enum logic [7:0] {
		MT32_MODE_MUNT  = 8'hA1,
		MT32_MODE_FLUID = 8'hA2
	} mt32_mode_e;

	// OSD info setting
	typedef enum logic [1:0] {
		INFO_OFF       = 2'd0,
		// OSD popup on each mode change
		INFO_ON_CHANGE = 2'd1,
		// LCD overlay always shown
		INFO_LCD_ON    = 2'd2,
		// LCD overlay shown after an update, then timed out
		INFO_LCD_AUTO  = 2'd3
	} info_mode_e;

	// Synth status as reported over the link
	typedef struct packed {
		mt32_mode_e mode;
		// Munt ROM select
		logic [7:0] rom;
		// FluidSynth soundfont index
		logic [7:0] sf;
		// Toggles on every mode change
		logic       newmode;
	} mt32_stat_t;

endpackage

`default_nettype wire

/* design/clk_enable_gen.sv */
// Clock enable generator
`default_nettype none
`include "x68k_glue_cfg.svh"

module clk_enable_gen
	import x68k_ctrl_pkg::*;
(
	input  wire logic clk_sys,
	input  wire logic rst_n,
	input  wire logic turbo_req,
	input  wire logic snd_clockmode,
	output clk_en_t   clk_en
);

	localparam int SLOW_W = $clog2(`SND_SLOW_TERM + 1);
	localparam int FAST_W = $clog2(`SND_FAST_TERM + 1);
	localparam int OPN_W  = $clog2(`OPN_TERM + 1);

	localparam logic [SLOW_W-1:0] SLOW_TERM = SLOW_W'(`SND_SLOW_TERM);
	localparam logic [FAST_W-1:0] FAST_TERM = FAST_W'(`SND_FAST_TERM);
	localparam logic [OPN_W-1:0]  OPN_TERM  = OPN_W'(`OPN_TERM);
	// Half way round the system divider, the CPU negative phase slot
	localparam logic [`SYS_DIV_W-1:0] SYS_HALF = {1'b0, {(`SYS_DIV_W-1){1'b1}}};

	logic [`SYS_DIV_W-1:0] div_sys;
	logic [SLOW_W-1:0]     div_snd_slow;
	logic [FAST_W-1:0]     div_snd_fast;
	logic [OPN_W-1:0]      div_opn;
	logic                  turbo;

	// Terminal count decodes
	logic sys_wrap;
	logic slow_wrap;
	logic fast_wrap;
	logic opn_wrap;

	assign sys_wrap  = &div_sys;
	assign slow_wrap = (div_snd_slow == SLOW_TERM);
	assign fast_wrap = (div_snd_fast == FAST_TERM);
	assign opn_wrap  = (div_opn == OPN_TERM);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_sys      <= '0;
			div_snd_slow <= '0;
			div_snd_fast <= '0;
			div_opn      <= '0;
			turbo        <= 1'b0;
			clk_en       <= '0;
		end else begin
			// Free-running, system divider wraps by itself
			div_sys      <= div_sys + 1'b1;
			div_snd_slow <= slow_wrap ? '0 : div_snd_slow + 1'b1;
			div_snd_fast <= fast_wrap ? '0 : div_snd_fast + 1'b1;
			div_opn      <= opn_wrap ? '0 : div_opn + 1'b1;

			// Speed only changes on a bus cycle boundary
			if (sys_wrap)
				turbo <= turbo_req;

			clk_en.sys_ce  <= sys_wrap;
			// Turbo runs the CPU phases on alternate cycles
			clk_en.mpu_cep <= turbo ? div_sys[0] : sys_wrap;
			clk_en.mpu_cen <= turbo ? ~div_sys[0] : (div_sys == SYS_HALF);
			clk_en.snd_ce  <= snd_clockmode ? slow_wrap : fast_wrap;
			clk_en.opn_ce  <= {opn_wrap, slow_wrap};
		end
	end

	// CPU phases must never overlap, also across a turbo switch
	a_cep_cen_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(clk_en.mpu_cep && clk_en.mpu_cen));

endmodule

`default_nettype wire

/* design/reset_loader_bridge.sv */
// Core reset and ROM loader bridge
`default_nettype none

module reset_loader_bridge
	import x68k_ctrl_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     rst_n,
	input  wire rst_src_t rst_src,
	input  wire host_dl_t host_dl,
	input  wire logic     ldr_ack,
	output logic          core_rst_n,
	output ldr_ctl_t      ldr
);

	// Delayed copies for edge detection
	logic dl_q;
	logic ack_q;
	logic menu_q;

	logic dl_rise;
	logic dl_fall;
	logic ack_rise;
	logic menu_fall;

	// Menu reset released at least once since power up
	logic init_done;
	// Download has started, core may leave reset
	logic armed;
	logic ldr_wr;
	logic ldr_done;

	assign dl_rise   = ~dl_q & host_dl.download;
	assign dl_fall   = dl_q & ~host_dl.download;
	assign ack_rise  = ~ack_q & ldr_ack;
	assign menu_fall = menu_q & ~rst_src.menu;

	////////////////////////////////////////////////////////////
	// Core reset
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_q       <= 1'b0;
			ack_q      <= 1'b0;
			menu_q     <= 1'b0;
			init_done  <= 1'b0;
			armed      <= 1'b0;
			core_rst_n <= 1'b0;
		end else begin
			dl_q   <= host_dl.download;
			ack_q  <= ldr_ack;
			menu_q <= rst_src.menu;

			if (menu_fall)
				init_done <= 1'b1;
			if (dl_rise)
				armed <= 1'b1;

			// Any active source pulls the core back into reset
			core_rst_n <= init_done & armed & ~(|rst_src);
		end
	end

	////////////////////////////////////////////////////////////
	// Loader write request
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ldr_wr   <= 1'b0;
			ldr_done <= 1'b0;
		end else begin
			// Core ack clears the request
			if (ack_rise & ldr_wr)
				ldr_wr <= 1'b0;
			// New host byte wins over a clear in the same cycle
			if (host_dl.wr & ~ldr_done)
				ldr_wr <= 1'b1;
			// End of transfer locks the loader out
			if (dl_fall)
				ldr_done <= 1'b1;
		end
	end

	assign ldr.aen  = host_dl.download & ~ldr_done;
	assign ldr.wr   = ldr_wr;
	assign ldr.done = ldr_done;

	// No write request may start once the image is loaded
	a_no_wr_after_done: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ldr_done |=> !$rose(ldr_wr));

endmodule

`default_nettype wire

/* design/mt32_monitor.sv */
// MT32 synth monitor and LCD overlay
`default_nettype none
`include "x68k_glue_cfg.svh"

module mt32_monitor
	import x68k_media_pkg::*;
#(
	parameter int lcd_hold_cycles = `LCD_HOLD_DEFAULT
) (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	input  wire mt32_stat_t mt32,
	input  wire info_mode_e info_mode,
	input  wire logic       lcd_update,
	input  wire logic       lcd_en,
	input  wire logic       lcd_pix,
	input  wire pixel_t     pix_in,
	output logic            info_req,
	output logic [3:0]      info_disp,
	output pixel_t          pix_out
);

	localparam int HOLD_W = $clog2(lcd_hold_cycles + 1);
	localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(lcd_hold_cycles);

	// Two-stage history of the mode toggle from the synth board
	logic              newmode_q1;
	logic              newmode_q2;
	logic              update_q;
	logic              lcd_on;
	logic [HOLD_W-1:0] hold_cnt;

	// Replace top two bits with the LCD dot, shift the colour down
	function automatic logic [7:0] blend(input logic [7:0] ch, input logic dot);
		return {{2{dot}}, ch[7:2]};
	endfunction

	////////////////////////////////////////////////////////////
	// Mode change and info code
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			newmode_q1 <= 1'b0;
			newmode_q2 <= 1'b0;
			info_req   <= 1'b0;
		end else begin
			newmode_q1 <= mt32.newmode;
			newmode_q2 <= newmode_q1;
			// One strobe per toggle, only when popups are wanted
			info_req   <= (newmode_q1 ^ newmode_q2) && (info_mode == INFO_ON_CHANGE);
		end
	end

	// Codes 1..8 are soundfonts, 9..11 Munt ROMs, 12 unknown
	always_ff @(posedge clk_sys) begin
		case (mt32.mode)
			MT32_MODE_FLUID: info_disp <= 4'd1 + {1'b0, mt32.sf[2:0]};
			MT32_MODE_MUNT: begin
				case (mt32.rom)
					8'd0:    info_disp <= 4'd9;
					8'd1:    info_disp <= 4'd10;
					8'd2:    info_disp <= 4'd11;
					default: info_disp <= 4'd12;
				endcase
			end
			default: info_disp <= 4'd12;
		endcase
	end

	////////////////////////////////////////////////////////////
	// LCD on/off and auto-off timer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			update_q <= 1'b0;
			lcd_on   <= 1'b0;
			hold_cnt <= '0;
		end else begin
			update_q <= lcd_update;
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			case (info_mode)
				INFO_LCD_ON: lcd_on <= 1'b1;
				INFO_LCD_AUTO: begin
					// Timer ran out
					if (hold_cnt == '0)
						lcd_on <= 1'b0;
					// Fresh LCD content restarts the hold time
					if (lcd_update ^ update_q) begin
						lcd_on   <= 1'b1;
						hold_cnt <= HOLD_LOAD;
					end
				end
				default: lcd_on <= 1'b0;
			endcase
		end
	end

	// Overlay blend, lcd_en marks the LCD window in the frame
	always_comb begin
		if (lcd_on && lcd_en) begin
			pix_out.r = blend(pix_in.r, lcd_pix);
			pix_out.g = blend(pix_in.g, lcd_pix);
			pix_out.b = blend(pix_in.b, lcd_pix);
		end else begin
			pix_out = pix_in;
		end
	end

endmodule

`default_nettype wire

/* design/audio_compressor.sv */
// Audio mixer and dynamic compressor
`default_nettype none
`include "x68k_glue_cfg.svh"

module audio_compressor
	import x68k_media_pkg::*;
(
	input  wire logic    clk_sys,
	input  wire logic    rst_n,
	input  wire sample_t core_audio,
	input  wire sample_t mt32_audio,
	input  wire logic    mt32_mute,
	input  wire logic    curve_sel,
	output sample_t      audio_out
);

	// Curve constants as 16-bit magnitudes
	localparam logic [15:0] KNEE1 = 16'(`CMP_X1);
	localparam logic [15:0] BASE1 = 16'(`CMP_B1);
	localparam logic [15:0] FDIV1 = 16'(`CMP_F1);
	localparam logic [15:0] AMUL1 = 16'(`CMP_A1);
	localparam logic [15:0] KNEE2 = 16'(`CMP_X2);
	localparam logic [15:0] BASE2 = 16'(`CMP_B2);
	localparam logic [15:0] FDIV2 = 16'(`CMP_F2);
	localparam logic [15:0] AMUL2 = 16'(`CMP_A2);

	sample_t mix_q;
	logic    sel_q;

	// Boost below the knee, flatten above it, keep the sign
	// Full-scale negative maps to 32767 magnitude on both curves
	function automatic sample_t compress(input sample_t inp, input logic sel);
		logic [15:0] mag;
		logic [15:0] v1;
		logic [15:0] v2;
		logic [15:0] v;
		mag = inp[15] ? (~inp + 16'd1) : inp;
		v1  = (mag < KNEE1) ? 16'(mag * AMUL1) : 16'((mag - KNEE1) / FDIV1) + BASE1;
		v2  = (mag < KNEE2) ? 16'(mag * AMUL2) : 16'((mag - KNEE2) / FDIV2) + BASE2;
		v   = sel ? v2 : v1;
		return inp[15] ? sample_t'(~(v - 16'd1)) : sample_t'(v);
	endfunction

	////////////////////////////////////////////////////////////
	// Stage 1, mix
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mix_q <= '0;
			sel_q <= 1'b0;
		end else begin
			// Plain 16-bit add, wraps on overflow
			mix_q <= core_audio + (mt32_mute ? sample_t'(0) : mt32_audio);
			// Curve select travels with its sample
			sel_q <= curve_sel;
		end
	end

	////////////////////////////////////////////////////////////
	// Stage 2, compress
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			audio_out <= '0;
		else
			audio_out <= compress(mix_q, sel_q);
	end

endmodule

`default_nettype wire

/* design/activity_led.sv */
// Disk activity LED stretcher
`default_nettype none
`include "x68k_glue_cfg.svh"

module activity_led #(
	parameter int hold_cycles = `LED_HOLD_DEFAULT
) (
	input  wire logic clk_sys,
	input  wire logic rst_n,
	input  wire logic act,
	output logic      led
);

	localparam int CNT_W = $clog2(hold_cycles + 1);
	localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(hold_cycles);

	logic [CNT_W-1:0] cnt;

	// Each activity pulse reloads the full hold time
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			cnt <= '0;
		else if (act)
			cnt <= HOLD_LOAD;
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

	// Lit while time remains
	assign led = (cnt != '0);

endmodule

`default_nettype wire

/* design/x68k_glue_top.sv */
// X68000 platform glue top
`default_nettype none
`include "x68k_glue_cfg.svh"

module x68k_glue_top
	import x68k_ctrl_pkg::*, x68k_media_pkg::*;
#(
	parameter int lcd_hold_cycles = `LCD_HOLD_DEFAULT,
	parameter int led_hold_cycles = `LED_HOLD_DEFAULT
) (
	input  wire logic       clk_sys,
	input  wire logic       rst_n,
	// Core clocking and reset
	input  wire logic       turbo_req,
	input  wire logic       snd_clockmode,
	input  wire rst_src_t   rst_src,
	input  wire host_dl_t   host_dl,
	input  wire logic       ldr_ack,
	// Synth status and LCD
	input  wire mt32_stat_t mt32,
	input  wire info_mode_e info_mode,
	input  wire logic       lcd_update,
	input  wire logic       lcd_en,
	input  wire logic       lcd_pix,
	input  wire pixel_t     pix_in,
	// Audio
	input  wire sample_t    core_audio,
	input  wire sample_t    mt32_audio,
	input  wire logic       mt32_mute,
	input  wire logic       curve_sel,
	input  wire logic       hdd_ack,
	output clk_en_t         clk_en,
	output logic            core_rst_n,
	output ldr_ctl_t        ldr,
	output logic            host_wait,
	output logic            info_req,
	output logic [3:0]      info_disp,
	output pixel_t          pix_out,
	output sample_t         audio_out,
	output logic            led_disk
);

	clk_enable_gen clk_enable_gen_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.turbo_req     (turbo_req),
		.snd_clockmode (snd_clockmode),
		.clk_en        (clk_en)
	);

	reset_loader_bridge reset_loader_bridge_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rst_src    (rst_src),
		.host_dl    (host_dl),
		.ldr_ack    (ldr_ack),
		.core_rst_n (core_rst_n),
		.ldr        (ldr)
	);

	// Host stalls while a loader write is still pending
	assign host_wait = ldr.wr;

	mt32_monitor #(
		.lcd_hold_cycles (lcd_hold_cycles)
	) mt32_monitor_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.mt32       (mt32),
		.info_mode  (info_mode),
		.lcd_update (lcd_update),
		.lcd_en     (lcd_en),
		.lcd_pix    (lcd_pix),
		.pix_in     (pix_in),
		.info_req   (info_req),
		.info_disp  (info_disp),
		.pix_out    (pix_out)
	);

	audio_compressor audio_compressor_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.core_audio (core_audio),
		.mt32_audio (mt32_audio),
		.mt32_mute  (mt32_mute),
		.curve_sel  (curve_sel),
		.audio_out  (audio_out)
	);

	activity_led #(
		.hold_cycles (led_hold_cycles)
	) activity_led_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.act     (hdd_ack),
		.led     (led_disk)
	);

endmodule

`default_nettype wire

/* verif/x68k_glue_tb.sv */
// X68000 glue testbench
`default_nettype none
`include "x68k_glue_cfg.svh"

module x68k_glue_tb
	import x68k_ctrl_pkg::*, x68k_media_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic       clk_sys;
	logic       rst_n;
	logic       turbo_req;
	logic       snd_clockmode;
	rst_src_t   rst_src;
	host_dl_t   host_dl;
	logic       ldr_ack;
	mt32_stat_t mt32;
	info_mode_e info_mode;
	logic       lcd_update;
	logic       lcd_en;
	logic       lcd_pix;
	pixel_t     pix_in;
	sample_t    core_audio;
	sample_t    mt32_audio;
	logic       mt32_mute;
	logic       curve_sel;
	logic       hdd_ack;
	clk_en_t    clk_en;
	logic       core_rst_n;
	ldr_ctl_t   ldr;
	logic       host_wait;
	logic       info_req;
	logic [3:0] info_disp;
	pixel_t     pix_out;
	sample_t    audio_out;
	logic       led_disk;
	integer     seed;

	// Short hold times so the timers run out quickly
	x68k_glue_top #(
		.lcd_hold_cycles (50),
		.led_hold_cycles (30)
	) x68k_glue_top_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.turbo_req     (turbo_req),
		.snd_clockmode (snd_clockmode),
		.rst_src       (rst_src),
		.host_dl       (host_dl),
		.ldr_ack       (ldr_ack),
		.mt32          (mt32),
		.info_mode     (info_mode),
		.lcd_update    (lcd_update),
		.lcd_en        (lcd_en),
		.lcd_pix       (lcd_pix),
		.pix_in        (pix_in),
		.core_audio    (core_audio),
		.mt32_audio    (mt32_audio),
		.mt32_mute     (mt32_mute),
		.curve_sel     (curve_sel),
		.hdd_ack       (hdd_ack),
		.clk_en        (clk_en),
		.core_rst_n    (core_rst_n),
		.ldr           (ldr),
		.host_wait     (host_wait),
		.info_req      (info_req),
		.info_disp     (info_disp),
		.pix_out       (pix_out),
		.audio_out     (audio_out),
		.led_disk      (led_disk)
	);

	// 50 MHz system clock
	always #10 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Error stop and compare tasks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic sample_check(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic pixel_check(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic enables_check(input string name, input clk_en_t got, input clk_en_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic loader_check(input string name, input ldr_ctl_t got, input ldr_ctl_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic code_check(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic bit_check(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic count_check(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////

	function automatic ldr_ctl_t loader_state(input logic aen, input logic wr, input logic done);
		ldr_ctl_t s;
		s.aen  = aen;
		s.wr   = wr;
		s.done = done;
		return s;
	endfunction

	// FluidSynth 1..8, Munt ROMs 9..11, unknown 12
	function automatic logic [3:0] info_code(input logic [7:0] mode, input logic [7:0] rom,
			input logic [7:0] sf);
		if (mode == 8'hA2)
			return 4'd1 + {1'b0, sf[2:0]};
		if (mode == 8'hA1 && rom < 8'd3)
			return 4'd9 + rom[3:0];
		return 4'd12;
	endfunction

	// LCD dot on the top two bits and colour shifted down
	function automatic pixel_t overlay_pixel(input pixel_t p, input logic dot);
		pixel_t o;
		o.r = {dot, dot, p.r[7:2]};
		o.g = {dot, dot, p.g[7:2]};
		o.b = {dot, dot, p.b[7:2]};
		return o;
	endfunction

	// Wrapping mix, then knee rule on the magnitude
	function automatic sample_t compress_model(input sample_t a, input sample_t b,
			input logic mute, input logic sel);
		sample_t sum;
		int      mag;
		int      knee;
		int      gain;
		int      slope;
		int      base;
		int      v;
		sum   = 16'(int'(a) + (mute ? 0 : int'(b)));
		mag   = (sum < 0) ? -int'(sum) : int'(sum);
		knee  = sel ? `CMP_X2 : `CMP_X1;
		gain  = sel ? `CMP_A2 : `CMP_A1;
		slope = sel ? `CMP_F2 : `CMP_F1;
		base  = sel ? `CMP_B2 : `CMP_B1;
		v     = (mag < knee) ? mag * gain : (mag - knee) / slope + base;
		return 16'((sum < 0) ? -v : v);
	endfunction

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Tally each enable over a window and check the CPU phases every cycle
	task automatic count_enables(input int cycles, output int n_sys, output int n_cep,
			output int n_cen, output int n_snd, output int n_opn0, output int n_opn1);
		n_sys  = 0;
		n_cep  = 0;
		n_cen  = 0;
		n_snd  = 0;
		n_opn0 = 0;
		n_opn1 = 0;
		repeat (cycles) begin
			@(negedge clk_sys);
			bit_check("mpu_cep and mpu_cen together", clk_en.mpu_cep & clk_en.mpu_cen, 1'b0);
			n_sys  += clk_en.sys_ce;
			n_cep  += clk_en.mpu_cep;
			n_cen  += clk_en.mpu_cen;
			n_snd  += clk_en.snd_ce;
			n_opn0 += clk_en.opn_ce[0];
			n_opn1 += clk_en.opn_ce[1];
		end
	endtask

	task automatic clock_enable_test();
		int ns;
		int ncp;
		int ncn;
		int nsd;
		int no0;
		int no1;
		// Normal CPU rate, slow sound rate
		@(posedge clk_sys);
		snd_clockmode <= 1'b1;
		repeat (2) @(posedge clk_sys);
		count_enables(40, ns, ncp, ncn, nsd, no0, no1);
		count_check("sys_ce count", ns, 10);
		count_check("mpu_cep count", ncp, 10);
		count_check("mpu_cen count", ncn, 10);
		count_check("snd_ce count slow", nsd, 4);
		count_check("opn_ce[0] count", no0, 4);
		count_check("opn_ce[1] count", no1, 2);
		// Fast sound rate
		@(posedge clk_sys);
		snd_clockmode <= 1'b0;
		repeat (2) @(posedge clk_sys);
		count_enables(40, ns, ncp, ncn, nsd, no0, no1);
		count_check("snd_ce count fast", nsd, 8);
		// Turbo is latched at the next wrap of the system divider
		@(posedge clk_sys);
		turbo_req <= 1'b1;
		repeat (8) @(posedge clk_sys);
		count_enables(40, ns, ncp, ncn, nsd, no0, no1);
		count_check("sys_ce count turbo", ns, 10);
		count_check("mpu_cep count turbo", ncp, 20);
		count_check("mpu_cen count turbo", ncn, 20);
		@(posedge clk_sys);
		turbo_req <= 1'b0;
		repeat (8) @(posedge clk_sys);
		count_enables(40, ns, ncp, ncn, nsd, no0, no1);
		count_check("mpu_cep count back to normal", ncp, 10);
	endtask

	task automatic wait_core_rst(input logic val, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (core_rst_n !== val) begin
			n++;
			if (n > limit)
				abort_run($sformatf("Timeout, core_rst_n did not become %b", val));
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_loader(input logic want_wr, input logic want_done, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (ldr.wr !== want_wr || ldr.done !== want_done) begin
			n++;
			if (n > limit)
				abort_run($sformatf("Timeout, loader did not reach wr=%b done=%b",
					want_wr, want_done));
			@(negedge clk_sys);
		end
	endtask

	task automatic host_write();
		@(posedge clk_sys);
		host_dl.wr <= 1'b1;
		@(posedge clk_sys);
		host_dl.wr <= 1'b0;
	endtask

	task automatic reset_loader_test();
		// Menu reset alone must not release the core
		@(posedge clk_sys);
		rst_src.menu <= 1'b1;
		repeat (2) @(posedge clk_sys);
		rst_src.menu <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		bit_check("core_rst_n without download", core_rst_n, 1'b0);
		// System reset clears the init flag again
		@(posedge clk_sys);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		bit_check("core_rst_n before init", core_rst_n, 1'b0);
		// Download alone must not release the core
		@(posedge clk_sys);
		host_dl.download <= 1'b1;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		bit_check("core_rst_n without menu reset", core_rst_n, 1'b0);
		loader_check("ldr during download", ldr, loader_state(1'b1, 1'b0, 1'b0));
		// Menu reset pulse completes the init sequence
		@(posedge clk_sys);
		rst_src.menu <= 1'b1;
		repeat (2) @(posedge clk_sys);
		rst_src.menu <= 1'b0;
		wait_core_rst(1'b1, 10);
		// Writes held until the core acks
		repeat (3) begin
			host_write();
			wait_loader(1'b1, 1'b0, 4);
			loader_check("ldr after write", ldr, loader_state(1'b1, 1'b1, 1'b0));
			bit_check("host_wait after write", host_wait, 1'b1);
			@(negedge clk_sys);
			bit_check("host_wait before ack", host_wait, 1'b1);
			@(posedge clk_sys);
			ldr_ack <= 1'b1;
			wait_loader(1'b0, 1'b0, 4);
			bit_check("host_wait after ack", host_wait, 1'b0);
			@(posedge clk_sys);
			ldr_ack <= 1'b0;
		end
		// End of download locks the loader
		@(posedge clk_sys);
		host_dl.download <= 1'b0;
		wait_loader(1'b0, 1'b1, 4);
		loader_check("ldr after download", ldr, loader_state(1'b0, 1'b0, 1'b1));
		host_write();
		repeat (3) begin
			@(negedge clk_sys);
			loader_check("ldr after late write", ldr, loader_state(1'b0, 1'b0, 1'b1));
		end
		bit_check("host_wait after late write", host_wait, 1'b0);
		// Button reset drops the core one cycle after it is sampled
		@(posedge clk_sys);
		rst_src.button <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		bit_check("core_rst_n on button", core_rst_n, 1'b0);
		@(posedge clk_sys);
		rst_src.button <= 1'b0;
		wait_core_rst(1'b1, 4);
	endtask

	task automatic toggle_and_count(input info_mode_e mode, output int n);
		@(posedge clk_sys);
		info_mode <= mode;
		repeat (2) @(posedge clk_sys);
		mt32.newmode <= ~mt32.newmode;
		n = 0;
		repeat (8) begin
			@(negedge clk_sys);
			n += info_req;
		end
	endtask

	task automatic info_code_test();
		logic [7:0] modes [4] = '{8'hA1, 8'hA2, 8'h00, 8'h5C};
		mt32_stat_t st;
		int         mi;
		int         ri;
		int         si;
		int         n;
		// Known and unknown modes, out-of-range ROM, soundfont above 7
		for (mi = 0; mi < 4; mi++) begin
			for (ri = 0; ri < 5; ri++) begin
				for (si = 0; si < 9; si++) begin
					st.mode    = mt32_mode_e'(modes[mi]);
					st.rom     = (ri < 4) ? 8'(ri) : 8'hFF;
					st.sf      = (si < 8) ? 8'(si) : 8'h2D;
					st.newmode = mt32.newmode;
					@(posedge clk_sys);
					mt32 <= st;
					@(posedge clk_sys);
					@(negedge clk_sys);
					code_check("info_disp", info_disp, info_code(modes[mi], st.rom, st.sf));
				end
			end
		end
		toggle_and_count(INFO_ON_CHANGE, n);
		count_check("info_req pulses with popups on", n, 1);
		toggle_and_count(INFO_OFF, n);
		count_check("info_req pulses with info off", n, 0);
	endtask

	// pix_in and lcd_pix held while waiting
	task automatic wait_overlay(input logic on, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (pix_out !== (on ? overlay_pixel(pix_in, lcd_pix) : pix_in)) begin
			n++;
			if (n > limit)
				abort_run($sformatf("Timeout, LCD overlay did not turn %s", on ? "on" : "off"));
			@(negedge clk_sys);
		end
	endtask

	task automatic lcd_overlay_test();
		@(posedge clk_sys);
		info_mode <= INFO_LCD_AUTO;
		lcd_en    <= 1'b1;
		lcd_pix   <= 1'b1;
		pix_in    <= 24'h5AC381;
		// Off after reset until the first update
		repeat (3) begin
			@(negedge clk_sys);
			pixel_check("pix_out before update", pix_out, pix_in);
		end
		@(posedge clk_sys);
		lcd_update <= ~lcd_update;
		wait_overlay(1'b1, 4);
		// Random video under the overlay with the LCD window on and off
		repeat (40) begin
			@(posedge clk_sys);
			pix_in  <= 24'($random(seed));
			lcd_pix <= 1'($random(seed));
			lcd_en  <= 1'($random(seed));
			@(negedge clk_sys);
			pixel_check("pix_out overlay", pix_out,
				lcd_en ? overlay_pixel(pix_in, lcd_pix) : pix_in);
		end
		@(posedge clk_sys);
		lcd_en <= 1'b1;
		// Auto-off within 55 cycles of the update
		wait_overlay(1'b0, 13);
		@(posedge clk_sys);
		info_mode <= INFO_LCD_ON;
		wait_overlay(1'b1, 4);
		repeat (80) begin
			@(negedge clk_sys);
			pixel_check("pix_out forced on", pix_out, overlay_pixel(pix_in, lcd_pix));
		end
		@(posedge clk_sys);
		info_mode <= INFO_OFF;
		wait_overlay(1'b0, 4);
	endtask

	task automatic audio_test();
		int         d_core [13] = '{0, 0, 14043, 14042, -14043, 7399, 7398, -7399,
			32767, -32768, -32768, 30000, -30000};
		int         d_mt [13] = '{0, 0, 0, 0, 5, 0, 0, 0, 0, 0, 0, 10000, -10000};
		logic [12:0] d_mute = 13'b0000000011000;
		logic [12:0] d_sel  = 13'b1010011100010;
		sample_t    exp_q [$];
		sample_t    cs;
		sample_t    ms;
		sample_t    expv;
		logic       mu;
		logic       se;
		int         total;
		int         i;
		// Directed corners first, then random pairs
		total = 13 + 200;
		for (i = 0; i < total + 2; i++) begin
			@(posedge clk_sys);
			if (i < total) begin
				if (i < 13) begin
					cs = 16'(d_core[i]);
					ms = 16'(d_mt[i]);
					mu = d_mute[i];
					se = d_sel[i];
				end else begin
					cs = 16'($random(seed));
					ms = 16'($random(seed));
					mu = 1'($random(seed));
					se = 1'($random(seed));
				end
				core_audio <= cs;
				mt32_audio <= ms;
				mt32_mute  <= mu;
				curve_sel  <= se;
				exp_q.push_back(compress_model(cs, ms, mu, se));
			end
			@(negedge clk_sys);
			// Two-cycle pipeline
			if (i >= 2) begin
				expv = exp_q.pop_front();
				sample_check("audio_out", audio_out, expv);
			end
		end
	endtask

	task automatic pulse_hdd_ack();
		@(posedge clk_sys);
		hdd_ack <= 1'b1;
		@(posedge clk_sys);
		hdd_ack <= 1'b0;
	endtask

	// Lit right after the ack and dark between 30 and 33 cycles later
	task automatic measure_led_hold();
		int n;
		n = 0;
		@(negedge clk_sys);
		bit_check("led_disk after ack", led_disk, 1'b1);
		while (led_disk) begin
			n++;
			if (n > 33)
				abort_run("Timeout, disk LED still lit 33 cycles after the last ack");
			@(negedge clk_sys);
		end
		if (n < 30)
			abort_run($sformatf("Disk LED went dark after %0d cycles, hold is 30", n));
	endtask

	task automatic disk_led_test();
		pulse_hdd_ack();
		measure_led_hold();
		// Retrigger mid-hold restarts the full hold
		pulse_hdd_ack();
		repeat (20) begin
			@(negedge clk_sys);
			bit_check("led_disk during hold", led_disk, 1'b1);
		end
		pulse_hdd_ack();
		measure_led_hold();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed          = 32'h5ea3_fe02;
		clk_sys       = 1'b0;
		rst_n         = 1'b0;
		turbo_req     = 1'b0;
		snd_clockmode = 1'b0;
		rst_src       = '0;
		host_dl       = '0;
		ldr_ack       = 1'b0;
		mt32          = '0;
		info_mode     = INFO_OFF;
		lcd_update    = 1'b0;
		lcd_en        = 1'b0;
		lcd_pix       = 1'b0;
		pix_in        = '0;
		core_audio    = '0;
		mt32_audio    = '0;
		mt32_mute     = 1'b0;
		curve_sel     = 1'b0;
		hdd_ack       = 1'b0;
		repeat (8) @(posedge clk_sys);
		rst_n <= 1'b1;
		// State one cycle after reset
		@(posedge clk_sys);
		@(negedge clk_sys);
		enables_check("clk_en after reset", clk_en, '0);
		bit_check("core_rst_n after reset", core_rst_n, 1'b0);
		bit_check("led_disk after reset", led_disk, 1'b0);
		sample_check("audio_out after reset", audio_out, '0);
		clock_enable_test();
		reset_loader_test();
		info_code_test();
		lcd_overlay_test();
		audio_test();
		disk_led_test();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
design/x68k_ctrl_pkg.sv
design/x68k_media_pkg.sv
design/clk_enable_gen.sv
design/reset_loader_bridge.sv
design/mt32_monitor.sv
design/audio_compressor.sv
design/activity_led.sv
design/x68k_glue_top.sv
verif/x68k_glue_tb.sv
